// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/cpu_sequencer.sv
      - hdl/cpu_regfile.sv
      - hdl/cpu_alu.sv
      - hdl/cpu_top.sv
  - target: test
    files:
      - dv/cpu_tb.sv

// File: all.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_sequencer.sv
hdl/cpu_regfile.sv
hdl/cpu_alu.sv
hdl/cpu_top.sv
dv/cpu_tb.sv

// File: dv/cpu_tb.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int NUM_INSTR  = 2000;
    localparam int CLK_PERIOD = 10;
    localparam int PROG_WORDS = 192;
    localparam int MEM_WORDS  = 256;

    logic  clock;
    logic  rst;
    word_t data;
    word_t address;
    word_t datao;
    logic  rw;

    word_t mem [MEM_WORDS];

    // reference model state
    word_t                    model_mem [MEM_WORDS];
    word_t                    model_regs [`CPU_NUM_REGS];
    logic [`CPU_NUM_REGS-1:0] model_flags;
    word_t                    model_pc;

    cpu_top u_dut (
        .clock   (clock),
        .rst     (rst),
        .data    (data),
        .address (address),
        .datao   (datao),
        .rw      (rw)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // memory answers within the cycle and writes at the edge that ends a store
    assign data = mem[address[7:0]];

    always @(posedge clock)
    begin
        if (rw == 1'b0)
        begin
            mem[address[7:0]] <= datao;
        end
    end

    initial
    begin
        #(NUM_INSTR * 3 * CLK_PERIOD + 1000);
        $display("timeout: %0d instructions did not complete in time", NUM_INSTR);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_rw(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            $display("*** FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_mem(input int index, input word_t actual, input word_t expected);
        if (actual !== expected)
        begin
            $display("** Error: mem[0x%02h] is 0x%08h, expected 0x%08h",
                     index, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "memory mismatch");
        end
    endtask

    // weighted toward alu ops, immediates and stores
    function automatic word_t random_instr();
        instr_t     ins;
        int         pick;
        logic [5:0] code;
        ins  = instr_t'($urandom());
        pick = $urandom_range(99);
        if (pick < 40)
        begin
            code = 6'($urandom_range(5));
            if (code == 6'd5)
            begin
                code = 6'd6;
            end
        end
        else if (pick < 55)
            code = 6'd5;
        else if (pick < 72)
            code = 6'd7;
        else if (pick < 80)
            code = 6'd8;
        else if (pick < 88)
            code = 6'd9;
        else if (pick < 93)
            code = 6'd10;
        else
            code = 6'($urandom_range(63, 11));
        ins.opcode = opcode_e'(code);
        // keep control flow inside the program area
        if (code == 6'd9 || code == 6'd10)
        begin
            ins.value = 16'($urandom_range(PROG_WORDS - 1));
        end
        return word_t'(ins);
    endfunction

    initial
    begin
        instr_t ins;
        word_t  ra;
        word_t  rb;
        word_t  loaded;
        word_t  res;
        word_t  next_pc;
        word_t  exp_addr;
        word_t  exp_datao;
        logic   exp_rw;
        logic   writes;

        void'($urandom(33));
        clock = 1'b0;
        rst   = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            if (i < PROG_WORDS)
                mem[i] = random_instr();
            else
                mem[i] = $urandom();
            model_mem[i] = mem[i];
        end
        for (int r = 0; r < `CPU_NUM_REGS; r++)
        begin
            model_regs[r] = '0;
        end
        model_flags = '0;
        model_pc    = `CPU_PC_RESET;

        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;

        // first cycle out of reset fetches from word 0
        @(negedge clock);
        check_word("address", address, word_t'(0));
        check_rw("rw", rw, 1'b1);
        check_word("datao", datao, word_t'(0));

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            check_word("fetch address", address, model_pc);
            check_rw("fetch rw", rw, 1'b1);
            check_word("fetch datao", datao, word_t'(0));

            ins       = instr_t'(model_mem[model_pc[7:0]]);
            ra        = model_regs[ins.src_a];
            rb        = model_regs[ins.src_b];
            exp_addr  = model_pc;
            exp_datao = '0;
            exp_rw    = 1'b1;
            loaded    = '0;
            if (ins.opcode == OP_LOAD)
            begin
                exp_addr = ra;
                loaded   = model_mem[ra[7:0]];
            end
            else if (ins.opcode == OP_STORE)
            begin
                exp_addr  = rb;
                exp_datao = ra;
                exp_rw    = 1'b0;
            end

            @(negedge clock);
            check_word("execute address", address, exp_addr);
            check_rw("execute rw", rw, exp_rw);
            check_word("execute datao", datao, exp_datao);
            if (ins.opcode == OP_STORE)
            begin
                model_mem[rb[7:0]] = ra;
            end

            @(negedge clock);
            check_word("writeback address", address, model_pc);
            check_rw("writeback rw", rw, 1'b1);
            check_word("writeback datao", datao, word_t'(0));

            res     = '0;
            writes  = 1'b1;
            next_pc = model_pc + 32'd1;
            case (ins.opcode)
                OP_ADD:   res = ra + rb;
                OP_SUB:   res = ra - rb;
                OP_AND:   res = ra & rb;
                OP_OR:    res = ra | rb;
                OP_XOR:   res = ra ^ rb;
                OP_LDI:   res = ins.highlow ? {ins.value, 16'h0000} : word_t'(ins.value);
                OP_CMPLT: res = (ra < rb) ? 32'd1 : 32'd0;
                OP_LOAD:  res = loaded;
                OP_BRF:
                begin
                    writes = 1'b0;
                    if (model_flags[ins.src_a])
                        next_pc = word_t'(ins.value);
                end
                OP_JMP:
                begin
                    writes  = 1'b0;
                    next_pc = word_t'(ins.value);
                end
                default:  writes = 1'b0;
            endcase
            if (writes)
            begin
                model_regs[ins.dst]  = res;
                model_flags[ins.dst] = (ins.opcode == OP_CMPLT) ? res[0] : (res == '0);
            end
            model_pc = next_pc;

            @(negedge clock);
        end

        for (int i = 0; i < MEM_WORDS; i++)
        begin
            check_mem(i, mem[i], model_mem[i]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: hdl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu
    import cpu_pkg::*;
(
    input  instr_t      instr,
    input  operands_t   operands,
    input  word_t       load_data,
    output alu_result_t alu
);

    word_t a;
    word_t b;
    word_t imm_word;

    assign a = operands.rega;
    assign b = operands.regb;

    // low half or high half placement of the 16-bit immediate
    assign imm_word = instr.highlow ? {instr.value, 16'h0000} : word_t'(instr.value);

    always_comb
    begin
        alu.result   = '0;
        alu.flag     = 1'b0;
        alu.write_en = 1'b0;
        alu.taken    = 1'b0;
        // branch target is the immediate, zero extended
        alu.target   = word_t'(instr.value);

        case (instr.opcode)
            OP_ADD:
            begin
                alu.result   = a + b;
                alu.write_en = 1'b1;
            end
            OP_SUB:
            begin
                alu.result   = a - b;
                alu.write_en = 1'b1;
            end
            OP_AND:
            begin
                alu.result   = a & b;
                alu.write_en = 1'b1;
            end
            OP_OR:
            begin
                alu.result   = a | b;
                alu.write_en = 1'b1;
            end
            OP_XOR:
            begin
                alu.result   = a ^ b;
                alu.write_en = 1'b1;
            end
            OP_LDI:
            begin
                alu.result   = imm_word;
                alu.write_en = 1'b1;
            end
            OP_CMPLT:
            begin
                alu.result   = word_t'(a < b);
                alu.write_en = 1'b1;
            end
            OP_LOAD:
            begin
                // load_data is only valid by write-back
                alu.result   = load_data;
                alu.write_en = 1'b1;
            end
            OP_BRF:    alu.taken = operands.flag_a;
            OP_JMP:    alu.taken = 1'b1;
            default:   alu.taken = 1'b0;
        endcase

        // compare puts its bit in the flag, everything else flags a zero result
        if (instr.opcode == OP_CMPLT)
        begin
            alu.flag = alu.result[0];
        end
        else
        begin
            alu.flag = (alu.result == '0);
        end
    end

endmodule

// File: hdl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path and bus address width
`define CPU_WORD_WIDTH 32

// general registers and flags share one count and one index
`define CPU_NUM_REGS 8

// first fetch address after reset
`define CPU_PC_RESET 32'h0000_0000

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
    typedef logic [15:0] imm_t;

    // codes 11 and up decode as no-ops
    typedef enum logic [5:0] {
        OP_ADD   = 6'd0,
        OP_SUB   = 6'd1,
        OP_AND   = 6'd2,
        OP_OR    = 6'd3,
        OP_XOR   = 6'd4,
        OP_LDI   = 6'd5,
        OP_CMPLT = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_BRF   = 6'd9,
        OP_JMP   = 6'd10
    } opcode_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_WRITEBACK
    } cpu_state_e;

    typedef struct packed {
        imm_t     value;
        logic     highlow;
        reg_idx_t dst;
        reg_idx_t src_b;
        reg_idx_t src_a;
        opcode_e  opcode;
    } instr_t;

    typedef struct packed {
        word_t rega;
        word_t regb;
        logic  flag_a;
        logic  flag_b;
    } operands_t;

    typedef struct packed {
        word_t result;
        logic  flag;
        logic  write_en;
        logic  taken;
        word_t target;
    } alu_result_t;

endpackage

// File: hdl/cpu_regfile.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_regfile
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  instr_t      instr,
    input  alu_result_t alu,
    input  logic        wb_en,
    output operands_t   operands
);

    word_t                   regs [`CPU_NUM_REGS];
    logic [`CPU_NUM_REGS-1:0] flags;

    // read side has no latency
    assign operands.rega   = regs[instr.src_a];
    assign operands.regb   = regs[instr.src_b];
    assign operands.flag_a = flags[instr.src_a];
    assign operands.flag_b = flags[instr.src_b];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wb_en && alu.write_en)
        begin
            // word and flag share the destination field
            regs[instr.dst]  <= alu.result;
            flags[instr.dst] <= alu.flag;
        end
    end

endmodule

// File: hdl/cpu_sequencer.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  word_t       data,
    input  operands_t   operands,
    input  alu_result_t alu,
    output word_t       address,
    output word_t       datao,
    output logic        rw,
    output instr_t      instr,
    output word_t       load_data,
    output logic        wb_en
);

    cpu_state_e state;
    word_t      pc;
    logic       is_load;
    logic       is_store;

    assign is_load  = (instr.opcode == OP_LOAD);
    assign is_store = (instr.opcode == OP_STORE);

    // register file writes only in the last cycle of an instruction
    assign wb_en = (state == ST_WRITEBACK);

    // fixed three-step sequence without stalls
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= ST_FETCH;
        end
        else
        begin
            case (state)
                ST_FETCH:     state <= ST_EXECUTE;
                ST_EXECUTE:   state <= ST_WRITEBACK;
                ST_WRITEBACK: state <= ST_FETCH;
                default:      state <= ST_FETCH;
            endcase
        end
    end

    // pc moves once per instruction, after the alu has resolved the branch
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= `CPU_PC_RESET;
        end
        else if (state == ST_WRITEBACK)
        begin
            if (alu.taken)
            begin
                pc <= alu.target;
            end
            else
            begin
                pc <= pc + word_t'(1);
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == ST_FETCH)
        begin
            instr <= instr_t'(data);
        end
        // memory answers in the same cycle, so capture it here for write-back
        if (state == ST_EXECUTE && is_load)
        begin
            load_data <= data;
        end
    end

    // only a store in execute pulls rw low
    always_comb
    begin
        address = pc;
        datao   = '0;
        rw      = 1'b1;
        if (state == ST_EXECUTE)
        begin
            if (is_load)
            begin
                address = operands.rega;
            end
            else if (is_store)
            begin
                address = operands.regb;
                datao   = operands.rega;
                rw      = 1'b0;
            end
        end
    end

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  word_t data,
    output word_t address,
    output word_t datao,
    output logic  rw
);

    instr_t      instr;
    word_t       load_data;
    logic        wb_en;
    operands_t   operands;
    alu_result_t alu;

    cpu_sequencer u_sequencer (
        .clock     (clock),
        .rst       (rst),
        .data      (data),
        .operands  (operands),
        .alu       (alu),
        .address   (address),
        .datao     (datao),
        .rw        (rw),
        .instr     (instr),
        .load_data (load_data),
        .wb_en     (wb_en)
    );

    cpu_regfile u_regfile (
        .clock    (clock),
        .rst      (rst),
        .instr    (instr),
        .alu      (alu),
        .wb_en    (wb_en),
        .operands (operands)
    );

    cpu_alu u_alu (
        .instr     (instr),
        .operands  (operands),
        .load_data (load_data),
        .alu       (alu)
    );

endmodule
